//--- gpr_file.sv
// General register file: two read ports, ESP/ESI/EDI taps,
// 32-bit writeback, stack commit of ESP and string-move step

`include "ra_consts.svh"

`default_nettype none

module gpr_file (
    input  logic                 clk,
    input  logic                 rst_n,

    // Operand reads
    input  ra_reg_pkg::reg_idx_t rd0_idx,
    input  ra_reg_pkg::reg_idx_t rd1_idx,
    output ra_reg_pkg::gpr_t     rd0_value,
    output ra_reg_pkg::gpr_t     rd1_value,
    output ra_reg_pkg::gpr_t     esi,
    output ra_reg_pkg::gpr_t     edi,
    output ra_reg_pkg::gpr_t     esp,

    // General writeback
    input  logic                 wb_en,
    input  ra_reg_pkg::reg_idx_t wb_idx,
    input  ra_reg_pkg::gpr_t     wb_data,

    // Committed stack pointer
    input  logic                 esp_commit_en,
    input  ra_reg_pkg::gpr_t     esp_commit_data,

    // String move
    input  logic                 movs_en,
    input  ra_op_pkg::size_e     movs_size,
    input  logic                 flag_df
);

    ra_reg_pkg::gpr_t regs [0:`RA_GPR_NUM-1];
    ra_reg_pkg::gpr_t movs_step;
    ra_reg_pkg::gpr_t esi_next;
    ra_reg_pkg::gpr_t edi_next;

    // Reads see the value before any write in this cycle
    assign rd0_value = regs[rd0_idx];
    assign rd1_value = regs[rd1_idx];
    assign esi       = regs[`RA_ESI_IDX];
    assign edi       = regs[`RA_EDI_IDX];
    assign esp       = regs[`RA_ESP_IDX];

    // DF set walks the strings downward
    assign movs_step = ra_op_pkg::size_step(movs_size);
    assign esi_next  = flag_df ? esi - movs_step : esi + movs_step;
    assign edi_next  = flag_df ? edi - movs_step : edi + movs_step;

    // Later assignments win: stack commit and movs override writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RA_GPR_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_en) begin
                regs[wb_idx] <= wb_data;
            end
            if (esp_commit_en) begin
                regs[`RA_ESP_IDX] <= esp_commit_data;
            end
            if (movs_en) begin
                regs[`RA_ESI_IDX] <= esi_next;
                regs[`RA_EDI_IDX] <= edi_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- gpr_scoreboard.sv
// Pending-write scoreboard for the general registers:
// one counter per register and the operand stall

`include "ra_consts.svh"

`default_nettype none

module gpr_scoreboard (
    input  logic                 clk,
    input  logic                 rst_n,

    // Issue side
    input  logic                 accept,
    input  ra_reg_pkg::reg_idx_t dst,
    input  logic                 dst_en,

    // Retire side
    input  logic                 wb_en,
    input  ra_reg_pkg::reg_idx_t wb_idx,

    // Registers the waiting instruction reads
    input  ra_reg_pkg::reg_idx_t src0,
    input  logic                 src0_en,
    input  ra_reg_pkg::reg_idx_t src1,
    input  logic                 src1_en,
    input  ra_op_pkg::stack_op_e stack_op,
    input  logic                 movs,

    output logic                 stall
);

    ra_reg_pkg::sb_cnt_t    pending_cnt [0:`RA_GPR_NUM-1];
    logic [`RA_GPR_NUM-1:0] cnt_inc;
    logic [`RA_GPR_NUM-1:0] cnt_dec;
    logic                   src0_busy;
    logic                   src1_busy;
    logic                   esp_busy;
    logic                   movs_busy;

    always_comb begin
        for (int i = 0; i < `RA_GPR_NUM; i++) begin
            cnt_inc[i] = accept && dst_en && (dst == ra_reg_pkg::reg_idx_t'(i));
            cnt_dec[i] = wb_en && (wb_idx == ra_reg_pkg::reg_idx_t'(i));
        end
    end

    // Issue and retire on the same register cancel out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RA_GPR_NUM; i++) begin
                pending_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `RA_GPR_NUM; i++) begin
                if (cnt_inc[i] && !cnt_dec[i]) begin
                    pending_cnt[i] <= pending_cnt[i] + 1'b1;
                end else if (cnt_dec[i] && !cnt_inc[i]) begin
                    pending_cnt[i] <= pending_cnt[i] - 1'b1;
                end
            end
        end
    end

    assign src0_busy = src0_en && (pending_cnt[src0] != '0);
    assign src1_busy = src1_en && (pending_cnt[src1] != '0);

    // Push and pop read ESP implicitly
    assign esp_busy  = (stack_op != ra_op_pkg::STK_NONE) &&
                       (pending_cnt[`RA_ESP_IDX] != '0);

    // String move reads and steps both pointers
    assign movs_busy = movs && ((pending_cnt[`RA_ESI_IDX] != '0) ||
                                (pending_cnt[`RA_EDI_IDX] != '0));

    assign stall = src0_busy || src1_busy || esp_busy || movs_busy;

endmodule

`default_nettype wire

//--- ra_consts.svh
// Register indices, widths and scoreboard counter size
// for the register access stage

`ifndef RA_CONSTS_SVH
`define RA_CONSTS_SVH

`default_nettype none

// Widths
`define RA_GPR_W     32
`define RA_SEG_W     16
`define RA_IDX_W     3
`define RA_SB_CNT_W  2

// Register counts
`define RA_GPR_NUM   8
`define RA_SEG_NUM   6

// General register numbers
`define RA_ESP_IDX   3'd4
`define RA_ESI_IDX   3'd6
`define RA_EDI_IDX   3'd7

// Segment order is ES, CS, SS, DS, FS, GS
`define RA_CS_IDX    3'd1
`define RA_SS_IDX    3'd2

`default_nettype wire

`endif

//--- ra_op_pkg.sv
// Decode-side types: operand size and stack operation,
// plus the byte step for each operand size

`default_nettype none

package ra_op_pkg;

    // Encoding follows decode, so DWORD is 3 but steps by 4
    typedef enum logic [1:0] {
        SZ_NONE  = 2'd0,
        SZ_BYTE  = 2'd1,
        SZ_WORD  = 2'd2,
        SZ_DWORD = 2'd3
    } size_e;

    // Bit 0 is push, bit 1 is pop
    typedef enum logic [1:0] {
        STK_NONE = 2'd0,
        STK_PUSH = 2'd1,
        STK_POP  = 2'd2
    } stack_op_e;

    // Byte count moved by one operand of the given size
    function automatic ra_reg_pkg::gpr_t size_step(size_e size);
        case (size)
            SZ_BYTE:  return ra_reg_pkg::gpr_t'(1);
            SZ_WORD:  return ra_reg_pkg::gpr_t'(2);
            SZ_DWORD: return ra_reg_pkg::gpr_t'(4);
            default:  return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- ra_reg_pkg.sv
// Register-side types: general and segment register values,
// register numbers and pending-write counts

`include "ra_consts.svh"

`default_nettype none

package ra_reg_pkg;

    // One general register value
    typedef logic [`RA_GPR_W-1:0] gpr_t;

    // One segment selector
    typedef logic [`RA_SEG_W-1:0] seg_t;

    // Register number, shared by general and segment files
    typedef logic [`RA_IDX_W-1:0] reg_idx_t;

    // Writes in flight to one general register
    typedef logic [`RA_SB_CNT_W-1:0] sb_cnt_t;

endpackage

`default_nettype wire

//--- register_access_asserts.sv
// Concurrent checks on the valid/ready handshake and the
// pending-write counters, bound into the register access top

`include "ra_consts.svh"

`default_nettype none

module register_access_asserts (
    input logic                                      clk,
    input logic                                      rst_n,
    input logic                                      d_valid,
    input logic                                      r_valid,
    input logic                                      accept,
    input logic                                      stall,
    input ra_reg_pkg::reg_idx_t                      dst,
    input logic                                      dst_en,
    input logic                                      wb_en,
    input ra_reg_pkg::reg_idx_t                      wb_idx,
    input logic [`RA_GPR_NUM*`RA_SB_CNT_W-1:0]       pending_cnt
);

    timeunit 1ns;
    timeprecision 1ps;

    valid_needs_decode: assert property (
        @(posedge clk) disable iff (!rst_n) r_valid |-> d_valid
    ) else $error("r_valid high while d_valid is low");

    no_accept_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall |-> !accept
    ) else $error("instruction accepted during an operand stall");

    // An issue without a matching retire must find room in the counter
    for (genvar i = 0; i < `RA_GPR_NUM; i++) begin : g_cnt
        logic issue_only;

        assign issue_only = accept && dst_en && (dst == ra_reg_pkg::reg_idx_t'(i)) &&
                            !(wb_en && (wb_idx == ra_reg_pkg::reg_idx_t'(i)));

        cnt_no_overflow: assert property (
            @(posedge clk) disable iff (!rst_n)
            issue_only |-> (pending_cnt[i*`RA_SB_CNT_W +: `RA_SB_CNT_W] != {`RA_SB_CNT_W{1'b1}})
        ) else $error("pending-write counter %0d overflows", i);
    end

endmodule

bind register_access_top register_access_asserts register_access_asserts0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .d_valid     (d_valid),
    .r_valid     (r_valid),
    .accept      (accept),
    .stall       (stall),
    .dst         (d_dst),
    .dst_en      (d_dst_en),
    .wb_en       (wb_reg_en),
    .wb_idx      (wb_reg_number),
    .pending_cnt ({gpr_scoreboard0.pending_cnt[7], gpr_scoreboard0.pending_cnt[6],
                   gpr_scoreboard0.pending_cnt[5], gpr_scoreboard0.pending_cnt[4],
                   gpr_scoreboard0.pending_cnt[3], gpr_scoreboard0.pending_cnt[2],
                   gpr_scoreboard0.pending_cnt[1], gpr_scoreboard0.pending_cnt[0]})
);

`default_nettype wire

//--- register_access_top.f
+incdir+.
ra_reg_pkg.sv
ra_op_pkg.sv
gpr_file.sv
segment_file.sv
gpr_scoreboard.sv
stack_tracker.sv
register_access_top.sv
register_access_asserts.sv
tb_register_access.sv

//--- register_access_top.sv
// Register access stage top: valid/ready gating with the operand
// stall, general and segment files, scoreboard and stack tracker

`default_nettype none

module register_access_top (
    input  logic                 clk,
    input  logic                 rst_n,

    // Decode side
    input  logic                 d_valid,
    output logic                 d_ready,
    input  ra_reg_pkg::reg_idx_t d_src0,
    input  logic                 d_src0_en,
    input  ra_reg_pkg::reg_idx_t d_src1,
    input  logic                 d_src1_en,
    input  ra_reg_pkg::reg_idx_t d_dst,
    input  logic                 d_dst_en,
    input  ra_op_pkg::size_e     d_size,
    input  ra_op_pkg::stack_op_e d_stack_op,
    input  logic                 d_movs,

    input  logic                 flag_df,

    // General writeback
    input  logic                 wb_reg_en,
    input  ra_reg_pkg::reg_idx_t wb_reg_number,
    input  ra_reg_pkg::gpr_t     wb_reg_data,

    // Segment writeback
    input  logic                 wb_seg_en,
    input  ra_reg_pkg::reg_idx_t wb_seg_number,
    input  ra_reg_pkg::seg_t     wb_seg_data,

    input  logic                 write_cs_enable,
    input  ra_reg_pkg::seg_t     write_cs,

    // Stack commit
    input  logic                 wb_stack_en,
    input  ra_op_pkg::size_e     wb_stack_size,
    input  ra_op_pkg::stack_op_e wb_stack_op,

    // Address generation side
    input  logic                 r_ready,
    output logic                 r_valid,
    output ra_reg_pkg::gpr_t     r_src0_value,
    output ra_reg_pkg::gpr_t     r_src1_value,
    output ra_reg_pkg::gpr_t     r_esi,
    output ra_reg_pkg::gpr_t     r_edi,
    output ra_reg_pkg::seg_t     r_ss,
    output ra_reg_pkg::gpr_t     r_stack_address,
    output ra_op_pkg::size_e     r_size,
    output ra_op_pkg::stack_op_e r_stack_op
);

    logic             stall;
    logic             accept;
    logic             movs_en;
    logic             esp_commit_en;
    ra_reg_pkg::gpr_t esp_commit_data;
    ra_reg_pkg::gpr_t committed_esp;

    // No pipe register, the handshake passes straight through
    assign r_valid = d_valid && !stall;
    assign d_ready = r_ready && !stall;
    assign accept  = d_valid && d_ready;

    // Pointers step only when the move actually leaves
    assign movs_en = accept && d_movs;

    assign r_size     = d_size;
    assign r_stack_op = d_stack_op;

    gpr_file gpr_file0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd0_idx         (d_src0),
        .rd1_idx         (d_src1),
        .rd0_value       (r_src0_value),
        .rd1_value       (r_src1_value),
        .esi             (r_esi),
        .edi             (r_edi),
        .esp             (committed_esp),
        .wb_en           (wb_reg_en),
        .wb_idx          (wb_reg_number),
        .wb_data         (wb_reg_data),
        .esp_commit_en   (esp_commit_en),
        .esp_commit_data (esp_commit_data),
        .movs_en         (movs_en),
        .movs_size       (d_size),
        .flag_df         (flag_df)
    );

    segment_file segment_file0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .wb_en           (wb_seg_en),
        .wb_idx          (wb_seg_number),
        .wb_data         (wb_seg_data),
        .write_cs_enable (write_cs_enable),
        .write_cs        (write_cs),
        .ss              (r_ss)
    );

    gpr_scoreboard gpr_scoreboard0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .accept   (accept),
        .dst      (d_dst),
        .dst_en   (d_dst_en),
        .wb_en    (wb_reg_en),
        .wb_idx   (wb_reg_number),
        .src0     (d_src0),
        .src0_en  (d_src0_en),
        .src1     (d_src1),
        .src1_en  (d_src1_en),
        .stack_op (d_stack_op),
        .movs     (d_movs),
        .stall    (stall)
    );

    stack_tracker stack_tracker0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .accept          (accept),
        .stack_op        (d_stack_op),
        .size            (d_size),
        .wb_en           (wb_reg_en),
        .wb_idx          (wb_reg_number),
        .wb_data         (wb_reg_data),
        .ss              (r_ss),
        .commit_en       (wb_stack_en),
        .commit_size     (wb_stack_size),
        .commit_op       (wb_stack_op),
        .esp             (committed_esp),
        .stack_address   (r_stack_address),
        .esp_commit_en   (esp_commit_en),
        .esp_commit_data (esp_commit_data)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the register access testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_register_access \
    -f register_access_top.f \
    -Mdir obj_dir -o sim_register_access
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_register_access
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

//--- segment_file.sv
// Segment register file: ES, CS, SS, DS, FS, GS with writeback
// and the direct CS write, SS read out

`include "ra_consts.svh"

`default_nettype none

module segment_file (
    input  logic                 clk,
    input  logic                 rst_n,

    // Segment writeback
    input  logic                 wb_en,
    input  ra_reg_pkg::reg_idx_t wb_idx,
    input  ra_reg_pkg::seg_t     wb_data,

    // Far jump or call loads CS directly
    input  logic                 write_cs_enable,
    input  ra_reg_pkg::seg_t     write_cs,

    output ra_reg_pkg::seg_t     ss
);

    ra_reg_pkg::seg_t segs [0:`RA_SEG_NUM-1];
    logic             wb_hit;

    // Numbers 6 and 7 name no segment register
    assign wb_hit = wb_en && (wb_idx < `RA_SEG_NUM);

    assign ss = segs[`RA_SS_IDX];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RA_SEG_NUM; i++) begin
                segs[i] <= '0;
            end
        end else begin
            if (wb_hit) begin
                segs[wb_idx] <= wb_data;
            end
            // Direct write takes CS over the writeback
            if (write_cs_enable) begin
                segs[`RA_CS_IDX] <= write_cs;
            end
        end
    end

endmodule

`default_nettype wire

//--- stack_tracker.sv
// Speculative stack pointer, stack address for push and pop,
// and the committed ESP step from writeback

`include "ra_consts.svh"

`default_nettype none

module stack_tracker (
    input  logic                 clk,
    input  logic                 rst_n,

    // Instruction in this stage
    input  logic                 accept,
    input  ra_op_pkg::stack_op_e stack_op,
    input  ra_op_pkg::size_e     size,

    // General writeback, watched for ESP loads
    input  logic                 wb_en,
    input  ra_reg_pkg::reg_idx_t wb_idx,
    input  ra_reg_pkg::gpr_t     wb_data,

    input  ra_reg_pkg::seg_t     ss,

    // Stack commit from writeback
    input  logic                 commit_en,
    input  ra_op_pkg::size_e     commit_size,
    input  ra_op_pkg::stack_op_e commit_op,
    input  ra_reg_pkg::gpr_t     esp,

    output ra_reg_pkg::gpr_t     stack_address,
    output logic                 esp_commit_en,
    output ra_reg_pkg::gpr_t     esp_commit_data
);

    ra_reg_pkg::gpr_t spec_esp;
    ra_reg_pkg::gpr_t spec_step;
    ra_reg_pkg::gpr_t esp_lowered;
    ra_reg_pkg::gpr_t esp_raised;
    ra_reg_pkg::gpr_t addr_base;
    ra_reg_pkg::gpr_t commit_step;
    logic             wb_to_esp;

    assign spec_step   = ra_op_pkg::size_step(size);
    assign esp_lowered = spec_esp - spec_step;
    assign esp_raised  = spec_esp + spec_step;
    assign wb_to_esp   = wb_en && (wb_idx == `RA_ESP_IDX);

    // Push stores below the current top, pop reads the top
    assign addr_base     = (stack_op == ra_op_pkg::STK_PUSH) ? esp_lowered : spec_esp;
    assign stack_address = ra_reg_pkg::gpr_t'(ss) + addr_base;

    // A plain ESP write reloads the tracker ahead of any stack op
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spec_esp <= '0;
        end else if (wb_to_esp) begin
            spec_esp <= wb_data;
        end else if (accept && (stack_op == ra_op_pkg::STK_PUSH)) begin
            spec_esp <= esp_lowered;
        end else if (accept && (stack_op == ra_op_pkg::STK_POP)) begin
            spec_esp <= esp_raised;
        end
    end

    // Architectural ESP moves only when the stack op retires
    assign commit_step = ra_op_pkg::size_step(commit_size);

    always_comb begin
        case (commit_op)
            ra_op_pkg::STK_PUSH: esp_commit_data = esp - commit_step;
            ra_op_pkg::STK_POP:  esp_commit_data = esp + commit_step;
            default:             esp_commit_data = esp;
        endcase
    end

    assign esp_commit_en = commit_en;

endmodule

`default_nettype wire

//--- tb_register_access.sv
// Directed testbench for the register access stage
// Clock, reset, watchdog, compare tasks and one task per behavior

`include "ra_consts.svh"

`default_nettype none

module tb_register_access;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_CYCLES     = 250;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 150;
    localparam int ACCEPT_LIMIT    = 8;

    logic                 clk;
    logic                 rst_n;
    logic                 d_valid;
    logic                 d_ready;
    ra_reg_pkg::reg_idx_t d_src0;
    ra_reg_pkg::reg_idx_t d_src1;
    ra_reg_pkg::reg_idx_t d_dst;
    logic                 d_src0_en;
    logic                 d_src1_en;
    logic                 d_dst_en;
    ra_op_pkg::size_e     d_size;
    ra_op_pkg::stack_op_e d_stack_op;
    logic                 d_movs;
    logic                 flag_df;
    logic                 wb_reg_en;
    ra_reg_pkg::reg_idx_t wb_reg_number;
    ra_reg_pkg::gpr_t     wb_reg_data;
    logic                 wb_seg_en;
    ra_reg_pkg::reg_idx_t wb_seg_number;
    ra_reg_pkg::seg_t     wb_seg_data;
    logic                 write_cs_enable;
    ra_reg_pkg::seg_t     write_cs;
    logic                 wb_stack_en;
    ra_op_pkg::size_e     wb_stack_size;
    ra_op_pkg::stack_op_e wb_stack_op;
    logic                 r_ready;
    logic                 r_valid;
    ra_reg_pkg::gpr_t     r_src0_value;
    ra_reg_pkg::gpr_t     r_src1_value;
    ra_reg_pkg::gpr_t     r_esi;
    ra_reg_pkg::gpr_t     r_edi;
    ra_reg_pkg::seg_t     r_ss;
    ra_reg_pkg::gpr_t     r_stack_address;
    ra_op_pkg::size_e     r_size;
    ra_op_pkg::stack_op_e r_stack_op;

    // Expected architectural state
    ra_reg_pkg::gpr_t     gpr_model [0:`RA_GPR_NUM-1];
    ra_reg_pkg::seg_t     ss_model;
    integer               seed;

    register_access_top i_register_access_top (.*);

    always #50 clk = ~clk;

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_gpr(string name, ra_reg_pkg::gpr_t expected, ra_reg_pkg::gpr_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_seg(string name, ra_reg_pkg::seg_t expected, ra_reg_pkg::seg_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("[FAIL] %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_size(string name, ra_op_pkg::size_e expected,
                              ra_op_pkg::size_e actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("[FAIL] %s: expected %s, actual %0d",
                                    name, expected.name(), actual));
        end
    endtask

    task automatic check_stack_op(string name, ra_op_pkg::stack_op_e expected,
                                  ra_op_pkg::stack_op_e actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("[FAIL] %s: expected %s, actual %0d",
                                    name, expected.name(), actual));
        end
    endtask

    // Let combinational outputs settle after the falling edge
    task automatic settle();
        #10;
    endtask

    task automatic next_cycle();
        @(negedge clk);
    endtask

    task automatic clear_instr();
        d_valid    = 1'b0;
        d_src0     = '0;
        d_src0_en  = 1'b0;
        d_src1     = '0;
        d_src1_en  = 1'b0;
        d_dst      = '0;
        d_dst_en   = 1'b0;
        d_size     = ra_op_pkg::SZ_NONE;
        d_stack_op = ra_op_pkg::STK_NONE;
        d_movs     = 1'b0;
    endtask

    // Hold d_valid until the handshake completes and drop it afterwards
    task automatic send_instr(string name);
        int waited;
        waited  = 0;
        d_valid = 1'b1;
        settle();
        while (!(r_valid && d_ready)) begin
            if (waited >= ACCEPT_LIMIT) begin
                stop_on_error($sformatf("%s: DUT did not accept the instruction within %0d cycles",
                                        name, ACCEPT_LIMIT));
            end
            next_cycle();
            settle();
            waited++;
        end
        next_cycle();
        d_valid = 1'b0;
    endtask

    // Issue a writer of idx and retire it through general writeback
    task automatic write_gpr(string name, ra_reg_pkg::reg_idx_t idx, ra_reg_pkg::gpr_t data);
        clear_instr();
        d_dst    = idx;
        d_dst_en = 1'b1;
        send_instr(name);
        clear_instr();
        wb_reg_en     = 1'b1;
        wb_reg_number = idx;
        wb_reg_data   = data;
        next_cycle();
        wb_reg_en      = 1'b0;
        gpr_model[idx] = data;
    endtask

    task automatic write_ss(ra_reg_pkg::seg_t data);
        wb_seg_en     = 1'b1;
        wb_seg_number = `RA_SS_IDX;
        wb_seg_data   = data;
        next_cycle();
        wb_seg_en = 1'b0;
        ss_model  = data;
    endtask

    task automatic test_reset_idle();
        for (int i = 0; i < `RA_GPR_NUM; i++) begin
            d_src0 = ra_reg_pkg::reg_idx_t'(i);
            d_src1 = ra_reg_pkg::reg_idx_t'(7 - i);
            settle();
            check_gpr("reset_idle src0", '0, r_src0_value);
            check_gpr("reset_idle src1", '0, r_src1_value);
            check_bit("reset_idle r_valid", 1'b0, r_valid);
            next_cycle();
        end
        check_seg("reset_idle r_ss", '0, r_ss);
    endtask

    task automatic test_writeback_visibility();
        ra_reg_pkg::gpr_t data;
        logic [31:0]      rnd;
        for (int i = 0; i < `RA_GPR_NUM; i++) begin
            clear_instr();
            d_dst    = ra_reg_pkg::reg_idx_t'(i);
            d_dst_en = 1'b1;
            send_instr("writeback_visibility issue");
            clear_instr();
            data          = $random(seed);
            d_src0        = ra_reg_pkg::reg_idx_t'(i);
            d_src1        = ra_reg_pkg::reg_idx_t'(i);
            wb_reg_en     = 1'b1;
            wb_reg_number = ra_reg_pkg::reg_idx_t'(i);
            wb_reg_data   = data;
            settle();
            check_gpr("writeback_visibility same cycle", gpr_model[i], r_src0_value);
            next_cycle();
            wb_reg_en    = 1'b0;
            gpr_model[i] = data;
            settle();
            check_gpr("writeback_visibility src0", data, r_src0_value);
            check_gpr("writeback_visibility src1", data, r_src1_value);
        end
        rnd = $random(seed);
        write_ss(rnd[15:0]);
        settle();
        check_seg("writeback_visibility ss", ss_model, r_ss);
        // CS write racing a CS writeback must leave SS alone
        rnd             = $random(seed);
        write_cs_enable = 1'b1;
        write_cs        = rnd[15:0];
        wb_seg_en       = 1'b1;
        wb_seg_number   = `RA_CS_IDX;
        wb_seg_data     = rnd[31:16];
        next_cycle();
        write_cs_enable = 1'b0;
        wb_seg_en       = 1'b0;
        settle();
        check_seg("writeback_visibility ss after cs", ss_model, r_ss);
        rnd = $random(seed);
        write_ss(rnd[15:0]);
        settle();
        check_seg("writeback_visibility ss rewrite", ss_model, r_ss);
    endtask

    task automatic test_scoreboard_stall();
        ra_reg_pkg::gpr_t data;
        clear_instr();
        d_dst    = 3'd3;
        d_dst_en = 1'b1;
        send_instr("scoreboard_stall issue");
        clear_instr();
        d_src0    = 3'd3;
        d_src0_en = 1'b1;
        d_valid   = 1'b1;
        repeat (4) begin
            settle();
            check_bit("scoreboard_stall r_valid", 1'b0, r_valid);
            check_bit("scoreboard_stall d_ready", 1'b0, d_ready);
            next_cycle();
        end
        data          = $random(seed);
        wb_reg_en     = 1'b1;
        wb_reg_number = 3'd3;
        wb_reg_data   = data;
        settle();
        check_bit("scoreboard_stall wb cycle", 1'b0, r_valid);
        next_cycle();
        wb_reg_en    = 1'b0;
        gpr_model[3] = data;
        settle();
        check_bit("scoreboard_stall released r_valid", 1'b1, r_valid);
        check_bit("scoreboard_stall released d_ready", 1'b1, d_ready);
        check_gpr("scoreboard_stall value", data, r_src0_value);
        send_instr("scoreboard_stall dependent");

        // Two writers in flight need two writebacks
        clear_instr();
        d_dst    = 3'd3;
        d_dst_en = 1'b1;
        send_instr("scoreboard_stall first writer");
        send_instr("scoreboard_stall second writer");
        clear_instr();
        d_src0    = 3'd3;
        d_src0_en = 1'b1;
        d_valid   = 1'b1;
        for (int n = 0; n < 2; n++) begin
            settle();
            check_bit("scoreboard_stall double r_valid", 1'b0, r_valid);
            data          = $random(seed);
            wb_reg_en     = 1'b1;
            wb_reg_number = 3'd3;
            wb_reg_data   = data;
            next_cycle();
            wb_reg_en    = 1'b0;
            gpr_model[3] = data;
        end
        settle();
        check_bit("scoreboard_stall double released", 1'b1, r_valid);
        check_gpr("scoreboard_stall double value", gpr_model[3], r_src0_value);
        send_instr("scoreboard_stall double dependent");
        clear_instr();
    endtask

    task automatic test_back_pressure();
        ra_reg_pkg::gpr_t esi_old;
        ra_reg_pkg::gpr_t edi_old;
        esi_old = gpr_model[`RA_ESI_IDX];
        edi_old = gpr_model[`RA_EDI_IDX];
        clear_instr();
        d_movs  = 1'b1;
        d_size  = ra_op_pkg::SZ_DWORD;
        flag_df = 1'b0;
        r_ready = 1'b0;
        d_valid = 1'b1;
        repeat (4) begin
            settle();
            check_bit("back_pressure d_ready", 1'b0, d_ready);
            check_bit("back_pressure r_valid", 1'b1, r_valid);
            check_gpr("back_pressure esi held", esi_old, r_esi);
            check_gpr("back_pressure edi held", edi_old, r_edi);
            next_cycle();
        end
        r_ready = 1'b1;
        settle();
        check_bit("back_pressure released d_ready", 1'b1, d_ready);
        check_gpr("back_pressure esi accept cycle", esi_old, r_esi);
        next_cycle();
        d_valid = 1'b0;
        gpr_model[`RA_ESI_IDX] = esi_old + 32'd4;
        gpr_model[`RA_EDI_IDX] = edi_old + 32'd4;
        settle();
        check_gpr("back_pressure esi stepped", gpr_model[`RA_ESI_IDX], r_esi);
        check_gpr("back_pressure edi stepped", gpr_model[`RA_EDI_IDX], r_edi);
        clear_instr();
    endtask

    task automatic test_stack();
        ra_reg_pkg::gpr_t esp_val;
        ra_reg_pkg::gpr_t ss_ext;
        logic [31:0]      rnd;
        rnd = $random(seed);
        write_ss(rnd[15:0]);
        esp_val      = $random(seed);
        esp_val[1:0] = 2'b00;
        write_gpr("stack esp load", `RA_ESP_IDX, esp_val);
        ss_ext = {16'h0000, ss_model};

        clear_instr();
        d_stack_op = ra_op_pkg::STK_PUSH;
        d_size     = ra_op_pkg::SZ_DWORD;
        d_valid    = 1'b1;
        settle();
        check_gpr("stack push address", ss_ext + esp_val - 32'd4, r_stack_address);
        check_stack_op("stack push r_stack_op", ra_op_pkg::STK_PUSH, r_stack_op);
        check_size("stack push r_size", ra_op_pkg::SZ_DWORD, r_size);
        send_instr("stack push");

        // Pop reads from the lowered top left by the push
        clear_instr();
        d_stack_op = ra_op_pkg::STK_POP;
        d_size     = ra_op_pkg::SZ_DWORD;
        d_valid    = 1'b1;
        settle();
        check_gpr("stack pop address", ss_ext + esp_val - 32'd4, r_stack_address);
        check_stack_op("stack pop r_stack_op", ra_op_pkg::STK_POP, r_stack_op);
        send_instr("stack pop");
        clear_instr();

        wb_stack_en   = 1'b1;
        wb_stack_size = ra_op_pkg::SZ_WORD;
        wb_stack_op   = ra_op_pkg::STK_PUSH;
        next_cycle();
        wb_stack_en = 1'b0;
        gpr_model[`RA_ESP_IDX] = esp_val - 32'd2;
        d_src0 = `RA_ESP_IDX;
        settle();
        check_gpr("stack commit esp", gpr_model[`RA_ESP_IDX], r_src0_value);
    endtask

    task automatic movs_step_case(ra_op_pkg::size_e size, ra_reg_pkg::gpr_t step, logic df);
        string name;
        name = $sformatf("string_move %s df=%0d", size.name(), df);
        clear_instr();
        d_movs  = 1'b1;
        d_size  = size;
        flag_df = df;
        send_instr(name);
        clear_instr();
        if (df) begin
            gpr_model[`RA_ESI_IDX] = gpr_model[`RA_ESI_IDX] - step;
            gpr_model[`RA_EDI_IDX] = gpr_model[`RA_EDI_IDX] - step;
        end else begin
            gpr_model[`RA_ESI_IDX] = gpr_model[`RA_ESI_IDX] + step;
            gpr_model[`RA_EDI_IDX] = gpr_model[`RA_EDI_IDX] + step;
        end
        settle();
        check_gpr({name, " esi"}, gpr_model[`RA_ESI_IDX], r_esi);
        check_gpr({name, " edi"}, gpr_model[`RA_EDI_IDX], r_edi);
    endtask

    task automatic test_string_move();
        for (int df = 0; df < 2; df++) begin
            movs_step_case(ra_op_pkg::SZ_NONE, 32'd0, df[0]);
            movs_step_case(ra_op_pkg::SZ_BYTE, 32'd1, df[0]);
            movs_step_case(ra_op_pkg::SZ_WORD, 32'd2, df[0]);
            movs_step_case(ra_op_pkg::SZ_DWORD, 32'd4, df[0]);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error($sformatf("Watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        seed            = 32'h5a54da3a;
        clk             = 1'b0;
        rst_n           = 1'b0;
        clear_instr();
        flag_df         = 1'b0;
        wb_reg_en       = 1'b0;
        wb_reg_number   = '0;
        wb_reg_data     = '0;
        wb_seg_en       = 1'b0;
        wb_seg_number   = '0;
        wb_seg_data     = '0;
        write_cs_enable = 1'b0;
        write_cs        = '0;
        wb_stack_en     = 1'b0;
        wb_stack_size   = ra_op_pkg::SZ_NONE;
        wb_stack_op     = ra_op_pkg::STK_NONE;
        r_ready         = 1'b1;
        for (int i = 0; i < `RA_GPR_NUM; i++) begin
            gpr_model[i] = '0;
        end
        ss_model = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_idle();
        test_writeback_visibility();
        test_scoreboard_stall();
        test_back_pressure();
        test_stack();
        test_string_move();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
